//--- sources.f
src/station_pkg.sv
src/cfg_rd_if.sv
src/cfg_regfile.sv
src/cfg_arbiter.sv
src/amp_chain.sv
src/cav_mode.sv
src/prng.sv
src/adc_em.sv
src/station.sv
sim/station_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= station_tb
BUILD ?= obj_dir
LOG ?= sim.log
FILELIST ?= sources.f
VFLAGS ?= --binary --timing --assert

SRCS := $(shell cat $(FILELIST))
BIN := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- sim/station_tb.sv
`timescale 1ns/1ns

module station_tb;
  import station_pkg::*;

  localparam int MAX_CYCLES = 6000;
  // Cycles for a register write to reach every block
  localparam int SETTLE = 40;

  logic clk;
  logic rst_n;
  logic iq;
  sample_t drive;
  logic lb_write;
  logic [CFG_AW-1:0] lb_addr;
  logic [CFG_DW-1:0] lb_wdata;
  logic [CFG_DW-1:0] lb_rdata;
  adc_t a_field;
  adc_t a_forward;
  adc_t a_reflect;
  logic iq_out;

  // Software copy of the configuration and of the filter states
  int c_limit;
  int c_bw;
  int c_shift;
  int c_ofs [3];
  int amp_st [2];
  int cav_st [2];

  // Drive shape: 0 zero, 1 random, 2 step on I only, 3 constant
  int kind;
  int level;
  bit iq_next;

  // Expected codes per sample, three channels each
  int lo_q [$];
  int hi_q [$];
  int mode_q [$];
  bit iq_q [$];

  int quiet;
  int cycles;
  int value_errs;
  int other_errs;
  bit dith_seen;
  int dith_first;
  bit dith_varied;

  station UUT (
    .clk(clk), .rst_n(rst_n), .iq(iq), .drive(drive),
    .lb_write(lb_write), .lb_addr(lb_addr), .lb_wdata(lb_wdata), .lb_rdata(lb_rdata),
    .a_field(a_field), .a_forward(a_forward), .a_reflect(a_reflect), .iq_out(iq_out)
  );

  always #5 clk = ~clk;

  function automatic int sat(input int v, input int lo, input int hi);
    if (v > hi) return hi;
    if (v < lo) return lo;
    return v;
  endfunction

  // Converter rule, two LSBs dropped then offset and dither
  function automatic int adc_code(input int s, input int ofs, input int dith);
    return sat((s >>> 2) + ofs + dith, -32768, 32767);
  endfunction

  // One sample through clamp, low-pass and cavity decay
  function automatic void ref_step(input int d, input bit ch,
                                   output int f, output int w, output int r);
    int c;
    c = d;
    if (d > c_limit) begin
      c = c_limit;
    end else if (d < -c_limit) begin
      c = -c_limit;
    end
    amp_st[ch] = amp_st[ch] + ((c - amp_st[ch]) >>> c_bw);
    w = amp_st[ch];
    cav_st[ch] = cav_st[ch] + ((w - cav_st[ch]) >>> c_shift);
    f = cav_st[ch];
    r = sat(w - f, -131072, 131071);
  endfunction

  // One clock of stimulus, with its expected result queued
  task automatic tick(input int mode);
    int d;
    int s [3];
    @(negedge clk);
    lb_write = 1'b0;
    iq_next = ~iq_next;
    case (kind)
      1: d = int'($urandom_range(2 * level)) - level;
      2: d = iq_next ? level : 0;
      3: d = level;
      default: d = 0;
    endcase
    iq = iq_next;
    drive = sample_t'(d);
    ref_step(d, iq_next, s[0], s[1], s[2]);
    for (int ch = 0; ch < 3; ch++) begin
      lo_q.push_back(adc_code(s[ch], c_ofs[ch], 0));
      hi_q.push_back(adc_code(s[ch], c_ofs[ch], 3));
    end
    mode_q.push_back(mode);
    iq_q.push_back(iq_next);
  endtask

  task automatic write_reg(input logic [CFG_AW-1:0] a, input int v);
    tick(0);
    lb_write = 1'b1;
    lb_addr = a;
    lb_wdata = CFG_DW'(v);
    quiet = SETTLE + PIPE_LAT;
    case (a)
      REG_AMP_LIMIT: c_limit = v;
      REG_AMP_BW: c_bw = v;
      REG_CAV_SHIFT: c_shift = v;
      REG_OFS_FIELD: c_ofs[0] = v;
      REG_OFS_FWD: c_ofs[1] = v;
      REG_OFS_RFL: c_ofs[2] = v;
      default: ;
    endcase
  endtask

  // Readback is valid one cycle after the address
  task automatic read_reg(input logic [CFG_AW-1:0] a, output int v);
    tick(0);
    lb_addr = a;
    tick(0);
    v = int'(lb_rdata);
  endtask

  task automatic configure(input int limit, input int bw, input int shift, input int of,
                           input int ow, input int orf, input int en, input int seed);
    write_reg(REG_AMP_LIMIT, limit);
    write_reg(REG_AMP_BW, bw);
    write_reg(REG_CAV_SHIFT, shift);
    write_reg(REG_OFS_FIELD, of);
    write_reg(REG_OFS_FWD, ow);
    write_reg(REG_OFS_RFL, orf);
    write_reg(REG_PRNG_EN, en);
    write_reg(REG_PRNG_SEED, seed);
    repeat (SETTLE) tick(0);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    kind = 0;
    drive = '0;
    iq = 1'b0;
    lb_write = 1'b0;
    lo_q.delete();
    hi_q.delete();
    mode_q.delete();
    iq_q.delete();
    quiet = 0;
    c_limit = 0;
    c_bw = 0;
    c_shift = 0;
    for (int i = 0; i < 3; i++) begin
      c_ofs[i] = 0;
    end
    for (int i = 0; i < 2; i++) begin
      amp_st[i] = 0;
      cav_st[i] = 0;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // Mode 1 exact, mode 2 within the dither window
  task automatic check_chan(input string name, input int got, input int lo, input int hi,
                            input int m);
    if (m == 1) begin
      assert (got == lo) else begin
        value_errs++;
        $display("FAILED %0t %s got %0d expected %0d", $time, name, got, lo);
      end
    end else begin
      assert (got >= lo && got <= hi) else begin
        value_errs++;
        $display("FAILED %0t %s got %0d expected %0d..%0d", $time, name, got, lo, hi);
      end
      if (!dith_seen) begin
        dith_seen = 1'b1;
        dith_first = got - lo;
      end else if (got - lo != dith_first) begin
        dith_varied = 1'b1;
      end
    end
  endtask

  // Compare ADC outputs against samples queued PIPE_LAT cycles ago
  always begin : compare
    int m;
    bit iq_exp;
    int lo [3];
    int hi [3];
    @(negedge clk);
    #1;
    if (mode_q.size() > PIPE_LAT) begin
      m = mode_q.pop_front();
      iq_exp = iq_q.pop_front();
      for (int ch = 0; ch < 3; ch++) begin
        lo[ch] = lo_q.pop_front();
        hi[ch] = hi_q.pop_front();
      end
      if (quiet == 0 && m != 0) begin
        assert (iq_out == iq_exp) else begin
          value_errs++;
          $display("FAILED %0t iq_out got %0d expected %0d", $time, iq_out, iq_exp);
        end
        check_chan("a_field", int'(a_field), lo[0], hi[0], m);
        check_chan("a_forward", int'(a_forward), lo[1], hi[1], m);
        check_chan("a_reflect", int'(a_reflect), lo[2], hi[2], m);
      end
    end
    if (quiet > 0) begin
      quiet--;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs + 1);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int v;
    int exp_v;
    void'($urandom(32'h6f9b));
    clk = 1'b0;
    rst_n = 1'b0;
    iq = 1'b0;
    drive = '0;
    lb_write = 1'b0;
    lb_addr = '0;
    lb_wdata = '0;
    kind = 0;
    level = 0;
    iq_next = 1'b0;
    quiet = 0;
    cycles = 0;
    value_errs = 0;
    other_errs = 0;
    dith_seen = 1'b0;
    dith_first = 0;
    dith_varied = 1'b0;

    // Reset state and register readback
    apply_reset();
    tick(0);
    check_chan("a_field", int'(a_field), 0, 0, 1);
    check_chan("a_forward", int'(a_forward), 0, 0, 1);
    check_chan("a_reflect", int'(a_reflect), 0, 0, 1);
    for (int a = 0; a < 8; a++) begin
      exp_v = (a * 32'h1357 + 11) & 32'h3ffff;
      write_reg(CFG_AW'(a), exp_v);
      read_reg(CFG_AW'(a), v);
      assert (v == exp_v) else begin
        value_errs++;
        $display("FAILED %0t lb_rdata got %0h expected %0h", $time, v, exp_v);
      end
    end

    // Clamp with the low-pass bypassed
    apply_reset();
    configure(50000, 0, 15, 0, 0, 0, 0, 0);
    kind = 1;
    level = 131071;
    repeat (300) tick(1);

    // Step on I, zero on Q
    apply_reset();
    configure(100000, 3, 4, 0, 0, 0, 0, 0);
    kind = 2;
    level = 90000;
    repeat (300) tick(1);

    // Full-scale drive against large offsets
    // Short decay lets the field swing far enough to clip
    apply_reset();
    configure(131071, 0, 2, 20000, 0, -20000, 0, 0);
    kind = 1;
    level = 131071;
    repeat (300) tick(1);

    // Dither window
    apply_reset();
    configure(131071, 0, 3, 0, 0, 0, 1, 32'h2b5c1);
    kind = 3;
    level = 40000;
    repeat (500) tick(2);
    kind = 0;
    repeat (PIPE_LAT + 2) tick(0);
    assert (dith_varied) else begin
      other_errs++;
      $display("Dither never changed any ADC output over the dithered run");
    end

    // Live update, rewritten once the states have settled on zero drive
    apply_reset();
    configure(60000, 1, 2, 0, 0, 0, 0, 0);
    kind = 1;
    level = 100000;
    repeat (200) tick(1);
    kind = 0;
    repeat (200) tick(1);
    write_reg(REG_CAV_SHIFT, 5);
    write_reg(REG_OFS_FIELD, 100);
    write_reg(REG_OFS_FWD, -50);
    write_reg(REG_OFS_RFL, 300);
    repeat (SETTLE) tick(0);
    kind = 1;
    repeat (200) tick(1);

    kind = 0;
    repeat (PIPE_LAT + 2) tick(0);
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- src/station.sv
`timescale 1ns/1ns

module station (
  input logic clk,
  input logic rst_n,
  input logic iq,
  input station_pkg::sample_t drive,
  input logic lb_write,
  input logic [station_pkg::CFG_AW-1:0] lb_addr,
  input logic [station_pkg::CFG_DW-1:0] lb_wdata,
  output logic [station_pkg::CFG_DW-1:0] lb_rdata,
  output station_pkg::adc_t a_field,
  output station_pkg::adc_t a_forward,
  output station_pkg::adc_t a_reflect,
  output logic iq_out
);
  import station_pkg::*;

  sample_t amp_out;
  sample_t field;
  sample_t forward;
  sample_t reflect;
  logic iq_amp;
  logic iq_cav;
  logic [31:0] rnd;

  // One read port per requester, one towards the register file
  cfg_rd_if rq [N_REQ] ();
  cfg_rd_if mem_port ();

  cfg_regfile regfile (
    .clk(clk), .rst_n(rst_n),
    .lb_write(lb_write), .lb_addr(lb_addr), .lb_wdata(lb_wdata), .lb_rdata(lb_rdata),
    .port(mem_port)
  );

  cfg_arbiter arb (
    .clk(clk), .rst_n(rst_n), .req_ports(rq), .mem(mem_port)
  );

  // Amplifier, clamp then low-pass
  amp_chain amp (
    .clk(clk), .rst_n(rst_n), .iq(iq), .drive(drive),
    .amp_out(amp_out), .iq_out(iq_amp), .cfg(rq[RQ_AMP])
  );

  // Cavity baseband model
  cav_mode cav (
    .clk(clk), .rst_n(rst_n), .iq(iq_amp), .amp_out(amp_out),
    .field(field), .forward(forward), .reflect(reflect),
    .iq_out(iq_cav), .cfg(rq[RQ_CAV])
  );

  // Shared dither source
  prng dither (
    .clk(clk), .rst_n(rst_n), .rnd(rnd), .cfg(rq[RQ_PRNG])
  );

  // Three converters, each on its own slice of the dither word
  adc_em #(.ofs_addr(REG_OFS_FIELD)) adc_field (
    .clk(clk), .rst_n(rst_n), .in(field), .rnd(rnd[1:0]),
    .adc(a_field), .cfg(rq[RQ_ADC_F])
  );

  adc_em #(.ofs_addr(REG_OFS_FWD)) adc_fwd (
    .clk(clk), .rst_n(rst_n), .in(forward), .rnd(rnd[3:2]),
    .adc(a_forward), .cfg(rq[RQ_ADC_W])
  );

  adc_em #(.ofs_addr(REG_OFS_RFL)) adc_rfl (
    .clk(clk), .rst_n(rst_n), .in(reflect), .rnd(rnd[5:4]),
    .adc(a_reflect), .cfg(rq[RQ_ADC_R])
  );

  // Flag follows the ADC register stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iq_out <= 1'b0;
    end else begin
      iq_out <= iq_cav;
    end
  end

endmodule

//--- src/adc_em.sv
`timescale 1ns/1ns

module adc_em #(
  parameter logic [station_pkg::CFG_AW-1:0] ofs_addr = station_pkg::REG_OFS_FIELD
) (
  input logic clk,
  input logic rst_n,
  input station_pkg::sample_t in,
  input logic [1:0] rnd,
  output station_pkg::adc_t adc,
  cfg_rd_if.requester cfg
);
  import station_pkg::*;

  logic req_on;
  logic pend;
  logic signed [17:0] ofs;
  logic signed [19:0] sum;

  // Offset register, refetched continuously
  assign cfg.req = req_on & ~pend;
  assign cfg.addr = ofs_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_on <= 1'b0;
      pend <= 1'b0;
      ofs <= '0;
    end else begin
      req_on <= 1'b1;
      pend <= cfg.gnt;
      if (pend) begin
        ofs <= cfg.rdata;
      end
    end
  end

  // Drop two LSBs, then offset plus 0..3 LSB of dither
  assign sum = {{4{in[17]}}, in[17:2]} + {{2{ofs[17]}}, ofs} + {18'd0, rnd};

  // Clip to the 16-bit converter range
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      adc <= '0;
    end else if (sum > ADC_MAX) begin
      adc <= ADC_MAX;
    end else if (sum < ADC_MIN) begin
      adc <= ADC_MIN;
    end else begin
      adc <= sum[15:0];
    end
  end

endmodule

//--- src/prng.sv
`timescale 1ns/1ns

module prng (
  input logic clk,
  input logic rst_n,
  output logic [31:0] rnd,
  cfg_rd_if.requester cfg
);
  import station_pkg::*;

  logic req_on;
  logic pend;
  logic sel;
  logic en;
  logic [17:0] seed;
  logic [31:0] lfsr;

  // Fetch loop over enable then seed
  assign cfg.req = req_on & ~pend;
  assign cfg.addr = sel ? REG_PRNG_SEED : REG_PRNG_EN;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_on <= 1'b0;
      pend <= 1'b0;
      sel <= 1'b0;
      en <= 1'b0;
      seed <= '0;
      lfsr <= {LFSR_SEED_HI, 18'd0};
    end else begin
      req_on <= 1'b1;
      pend <= cfg.gnt;
      if (pend) begin
        sel <= ~sel;
        if (sel) begin
          seed <= cfg.rdata;
        end else begin
          en <= cfg.rdata[0];
        end
      end
      // Idle reloads the seed, running steps the Galois shifter
      if (!en) begin
        lfsr <= {LFSR_SEED_HI, seed};
      end else begin
        lfsr <= (lfsr >> 1) ^ (lfsr[0] ? LFSR_POLY : 32'd0);
      end
    end
  end

  // No dither at all while disabled
  assign rnd = en ? lfsr : '0;

endmodule

//--- src/cav_mode.sv
`timescale 1ns/1ns

module cav_mode (
  input logic clk,
  input logic rst_n,
  input logic iq,
  input station_pkg::sample_t amp_out,
  output station_pkg::sample_t field,
  output station_pkg::sample_t forward,
  output station_pkg::sample_t reflect,
  output logic iq_out,
  cfg_rd_if.requester cfg
);
  import station_pkg::*;

  logic req_on;
  logic pend;
  logic [3:0] shift;
  sample_t in_q;
  logic iq1;
  sample_t f_i;
  sample_t f_q;
  sample_t cur;
  sample_t nxt;
  logic signed [18:0] diff;
  logic signed [18:0] sum;
  logic signed [18:0] rdiff;
  sample_t rfl;

  // Single register, refetched continuously
  assign cfg.req = req_on & ~pend;
  assign cfg.addr = REG_CAV_SHIFT;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_on <= 1'b0;
      pend <= 1'b0;
      shift <= '0;
    end else begin
      req_on <= 1'b1;
      pend <= cfg.gnt;
      if (pend) begin
        shift <= cfg.rdata[3:0];
      end
    end
  end

  // First-order decay toward the drive, per channel
  assign cur = iq1 ? f_i : f_q;
  assign diff = {in_q[17], in_q} - {cur[17], cur};
  assign sum = $signed({cur[17], cur}) + (diff >>> shift);
  assign nxt = sum[17:0];

  // Reflected wave, forward minus field
  // Can exceed 18 bits on a full-scale swing
  assign rdiff = {in_q[17], in_q} - {nxt[17], nxt};
  always_comb begin
    if (rdiff[18] != rdiff[17]) begin
      rfl = rdiff[18] ? SAMPLE_MIN : SAMPLE_MAX;
    end else begin
      rfl = rdiff[17:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_q <= '0;
      iq1 <= 1'b0;
      f_i <= '0;
      f_q <= '0;
      field <= '0;
      forward <= '0;
      reflect <= '0;
      iq_out <= 1'b0;
    end else begin
      // Stage 1 input register
      in_q <= amp_out;
      iq1 <= iq;
      // Stage 2 state update and outputs
      if (iq1) begin
        f_i <= nxt;
      end else begin
        f_q <= nxt;
      end
      field <= nxt;
      // Forward is the drive lined up with its field
      forward <= in_q;
      reflect <= rfl;
      iq_out <= iq1;
    end
  end

endmodule

//--- src/amp_chain.sv
`timescale 1ns/1ns

module amp_chain (
  input logic clk,
  input logic rst_n,
  input logic iq,
  input station_pkg::sample_t drive,
  output station_pkg::sample_t amp_out,
  output logic iq_out,
  cfg_rd_if.requester cfg
);
  import station_pkg::*;

  logic req_on;
  logic pend;
  logic sel;
  logic [16:0] limit_mag;
  logic [2:0] bw;
  sample_t lim;
  sample_t clamp_q;
  sample_t st_i;
  sample_t st_q;
  sample_t cur;
  sample_t nxt;
  logic iq1;
  logic signed [18:0] diff;
  logic signed [18:0] step;
  logic signed [18:0] sum;

  // Fetch loop over limit then bandwidth
  // Request drops for the data cycle, address moves after it
  assign cfg.req = req_on & ~pend;
  assign cfg.addr = sel ? REG_AMP_BW : REG_AMP_LIMIT;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_on <= 1'b0;
      pend <= 1'b0;
      sel <= 1'b0;
      limit_mag <= '0;
      bw <= '0;
    end else begin
      req_on <= 1'b1;
      pend <= cfg.gnt;
      if (pend) begin
        sel <= ~sel;
        if (sel) begin
          bw <= cfg.rdata[2:0];
        end else begin
          limit_mag <= cfg.rdata[16:0];
        end
      end
    end
  end

  // Limit is a magnitude, so keep it positive
  assign lim = sample_t'({1'b0, limit_mag});

  // Low-pass state of whichever channel is in stage 2
  assign cur = iq1 ? st_i : st_q;
  assign diff = {clamp_q[17], clamp_q} - {cur[17], cur};
  // Shift of zero passes the clamped sample straight through
  assign step = diff >>> bw;
  assign sum = {cur[17], cur} + step;
  // Result lies between cur and the input, so 18 bits hold it
  assign nxt = sum[17:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clamp_q <= '0;
      iq1 <= 1'b0;
      st_i <= '0;
      st_q <= '0;
      amp_out <= '0;
      iq_out <= 1'b0;
    end else begin
      // Stage 1, clamp to +/- limit
      if (drive > lim) begin
        clamp_q <= lim;
      end else if (drive < -lim) begin
        clamp_q <= -lim;
      end else begin
        clamp_q <= drive;
      end
      iq1 <= iq;
      // Stage 2, one-pole update per channel
      if (iq1) begin
        st_i <= nxt;
      end else begin
        st_q <= nxt;
      end
      amp_out <= nxt;
      iq_out <= iq1;
    end
  end

endmodule

//--- src/cfg_arbiter.sv
`timescale 1ns/1ns

module cfg_arbiter (
  input logic clk,
  input logic rst_n,
  cfg_rd_if.arbiter req_ports [station_pkg::N_REQ],
  cfg_rd_if.requester mem
);
  import station_pkg::*;

  logic [N_REQ-1:0] req_vec;
  logic [CFG_AW-1:0] addr_vec [N_REQ];
  logic [N_REQ-1:0] gnt_vec;
  logic [REQ_IW-1:0] last;
  logic [REQ_IW-1:0] win;
  logic [REQ_IW-1:0] rd_idx;
  logic rd_valid;

  // Flatten the interface array so the ports can be indexed at run time
  for (genvar g = 0; g < N_REQ; g++) begin : g_port
    assign req_vec[g] = req_ports[g].req;
    assign addr_vec[g] = req_ports[g].addr;
    assign req_ports[g].gnt = gnt_vec[g];
    // Data goes back only to the port granted last cycle
    assign req_ports[g].rdata = (rd_valid && rd_idx == REQ_IW'(g)) ? mem.rdata : '0;
  end

  // Search starts one past the last winner and wraps
  always_comb begin
    int cand;
    logic found;
    win = last;
    found = 1'b0;
    for (int k = 1; k <= N_REQ; k++) begin
      cand = int'(last) + k;
      if (cand >= N_REQ) begin
        cand = cand - N_REQ;
      end
      if (!found && req_vec[cand]) begin
        win = REQ_IW'(cand);
        found = 1'b1;
      end
    end
  end

  // Forward the winner onto the register file port
  assign mem.req = |req_vec;
  assign mem.addr = addr_vec[win];

  always_comb begin
    gnt_vec = '0;
    if (mem.gnt) begin
      gnt_vec[win] = 1'b1;
    end
  end

  // Remember who won, for rotation and for data return
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last <= REQ_IW'(N_REQ - 1);
      rd_idx <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= mem.gnt;
      if (mem.gnt) begin
        last <= win;
        rd_idx <= win;
      end
    end
  end

endmodule

//--- src/cfg_regfile.sv
`timescale 1ns/1ns

module cfg_regfile (
  input logic clk,
  input logic rst_n,
  input logic lb_write,
  input logic [station_pkg::CFG_AW-1:0] lb_addr,
  input logic [station_pkg::CFG_DW-1:0] lb_wdata,
  output logic [station_pkg::CFG_DW-1:0] lb_rdata,
  cfg_rd_if.arbiter port
);
  import station_pkg::*;

  logic [CFG_DW-1:0] regs [CFG_DEPTH];

  // Host writes land on the clock edge
  // Host readback follows the address by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < CFG_DEPTH; i++) begin
        regs[i] <= '0;
      end
      lb_rdata <= '0;
    end else begin
      if (lb_write) begin
        regs[lb_addr] <= lb_wdata;
      end
      lb_rdata <= regs[lb_addr];
    end
  end

  // Single shared port is always ready
  assign port.gnt = port.req;

  // Registered shared read, valid the cycle after the grant
  always_ff @(posedge clk) begin
    port.rdata <= regs[port.addr];
  end

endmodule

//--- src/cfg_rd_if.sv
`timescale 1ns/1ns

interface cfg_rd_if;
  import station_pkg::*;

  // Request side
  logic req;
  logic [CFG_AW-1:0] addr;
  // Answer side, data one cycle after grant
  logic gnt;
  logic [CFG_DW-1:0] rdata;

  modport requester (
    output req, addr,
    input gnt, rdata
  );

  modport arbiter (
    input req, addr,
    output gnt, rdata
  );

endinterface

//--- src/station_pkg.sv
package station_pkg;

  // Sample path word types
  typedef logic signed [17:0] sample_t;
  typedef logic signed [15:0] adc_t;

  // Saturation limits for both word sizes
  localparam sample_t SAMPLE_MAX = 18'sh1ffff;
  localparam sample_t SAMPLE_MIN = 18'sh20000;
  localparam adc_t ADC_MAX = 16'sh7fff;
  localparam adc_t ADC_MIN = 16'sh8000;

  // Register file geometry
  localparam int CFG_AW = 4;
  localparam int CFG_DW = 18;
  localparam int CFG_DEPTH = 2 ** CFG_AW;

  // Register map
  localparam logic [CFG_AW-1:0] REG_AMP_LIMIT = 4'd0;
  localparam logic [CFG_AW-1:0] REG_AMP_BW = 4'd1;
  localparam logic [CFG_AW-1:0] REG_CAV_SHIFT = 4'd2;
  localparam logic [CFG_AW-1:0] REG_OFS_FIELD = 4'd3;
  localparam logic [CFG_AW-1:0] REG_OFS_FWD = 4'd4;
  localparam logic [CFG_AW-1:0] REG_OFS_RFL = 4'd5;
  localparam logic [CFG_AW-1:0] REG_PRNG_EN = 4'd6;
  localparam logic [CFG_AW-1:0] REG_PRNG_SEED = 4'd7;

  // Configuration read requesters, in arbiter port order
  localparam int N_REQ = 6;
  localparam int REQ_IW = 3;
  localparam int RQ_AMP = 0;
  localparam int RQ_CAV = 1;
  localparam int RQ_ADC_F = 2;
  localparam int RQ_ADC_W = 3;
  localparam int RQ_ADC_R = 4;
  localparam int RQ_PRNG = 5;

  // Galois LFSR feedback mask, taps 32 22 2 1
  localparam logic [31:0] LFSR_POLY = 32'h8020_0003;
  // Fixed upper LFSR bits keep a zero seed from locking the register
  localparam logic [13:0] LFSR_SEED_HI = 14'h0001;

  // Drive in to ADC code out, amp 2 + cavity 2 + ADC 1
  localparam int PIPE_LAT = 5;

endpackage
